/* led_tracker.f */
design/tracker_pkg.sv
design/video_timing.sv
design/mask_threshold.sv
design/centroid_accum.sv
design/overlay_mux.sv
design/led_tracker_top.sv
bench/tb_led_tracker.sv

/* Makefile */
# Verilator build and run of the LED tracker testbench

TOP := tb_led_tracker

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -Wno-fatal --top-module $(TOP) --Mdir obj_dir -o sim_tb -f led_tracker.f

# the log decides pass or fail
run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module led_tracker_top -f led_tracker.f

clean:
	rm -rf obj_dir sim.log

/* bench/tb_led_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_led_tracker import tracker_pkg::*; ();

    // small raster keeps each frame short
    localparam int h_active = 16;
    localparam int h_front = 2;
    localparam int h_sync = 2;
    localparam int h_back = 2;
    localparam int v_active = 8;
    localparam int v_front = 1;
    localparam int v_sync = 1;
    // five blanking lines leave room for the ~34 cycle divide
    localparam int v_back = 3;
    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int frame_cycles = h_total * v_total;
    localparam int n_scenes = 6;
    localparam int watchdog_ns = (n_scenes + 2) * frame_cycles * 10;
    localparam rgb_t white = 24'hffffff;
    localparam rgb_t black = 24'h000000;

    // one row of the scene table with inclusive rectangle bounds
    typedef struct packed {
        logic [h_count_w-1:0] x0;
        logic [h_count_w-1:0] x1;
        logic [v_count_w-1:0] y0;
        logic [v_count_w-1:0] y1;
        channel_e             ch;
        thresh_t              th;
        display_e             mode;
        rgb_t                 bright;
        logic                 empty;
    } scene_t;

    logic      clk_pixel;
    logic      recent_reset;
    rgb_t      pixel_in;
    channel_e  channel;
    thresh_t   thresh;
    display_e  mode;
    coord_t    fetch_coord;
    video_px_t video_out;
    coord_t    com;
    logic      com_valid;

    scene_t scenes [n_scenes];
    int     cur_scene;
    // centre the DUT should be holding right now
    coord_t ref_com;
    rgb_t   next_pix;

    // last four fetches where entry 3 is the one video_out shows now
    coord_t hist_coord [4];
    rgb_t   hist_pix [4];
    int     hist_scene [4];
    logic   hist_valid [4];

    // cycles since reset left, used to place the raster
    int     raster_tick;
    coord_t raster_want;

    int     pulse_total;
    coord_t pulse_com;
    int     mismatch_count;
    int     fail_count;

    led_tracker_top #(
        .h_active(h_active),
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_active(v_active),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back)
    ) uut (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .pixel_in    (pixel_in),
        .channel     (channel),
        .thresh      (thresh),
        .mode        (mode),
        .fetch_coord (fetch_coord),
        .video_out   (video_out),
        .com         (com),
        .com_valid   (com_valid)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    function automatic scene_t make_scene(
        input int       x0,
        input int       x1,
        input int       y0,
        input int       y1,
        input channel_e ch,
        input int       lo,
        input int       hi,
        input display_e md,
        input rgb_t     bright,
        input logic     empty
    );
        scene_t s;
        s.x0 = h_count_w'(x0);
        s.x1 = h_count_w'(x1);
        s.y0 = v_count_w'(y0);
        s.y1 = v_count_w'(y1);
        s.ch = ch;
        s.th.lower = color_w'(lo);
        s.th.upper = color_w'(hi);
        s.mode = md;
        s.bright = bright;
        s.empty = empty;
        return s;
    endfunction

    function automatic logic is_active(input coord_t c);
        return (c.hcount < h_count_w'(h_active)) && (c.vcount < v_count_w'(v_active));
    endfunction

    // frame buffer holds a lit rectangle on a dim random background
    function automatic rgb_t model_pixel(input coord_t c, input scene_t s);
        rgb_t p;
        if ((c.hcount >= s.x0) && (c.hcount <= s.x1) &&
            (c.vcount >= s.y0) && (c.vcount <= s.y1)) begin
            p = s.bright;
        end else begin
            // dim values stay under every lower bound in the table
            p.red = color_w'($urandom % 100);
            p.green = color_w'($urandom % 100);
            p.blue = color_w'($urandom % 100);
        end
        return p;
    endfunction

    function automatic logic [color_w-1:0] channel_of(input rgb_t p, input channel_e ch);
        if (ch == ch_green) begin
            return p.green;
        end else if (ch == ch_blue) begin
            return p.blue;
        end
        return p.red;
    endfunction

    // mean over a rectangle axis is the mean of its index range
    function automatic int floor_mean(input int lo, input int hi);
        int sum;
        int n;
        sum = 0;
        n = 0;
        for (int k = lo; k <= hi; k++) begin
            sum += k;
            n++;
        end
        return sum / n;
    endfunction

    // output pixel the raster and display rules call for
    function automatic video_px_t expect_px(
        input coord_t c,
        input rgb_t   p,
        input scene_t s,
        input coord_t held
    );
        video_px_t            e;
        logic [color_w-1:0]   val;
        logic                 hit;
        logic                 on_line;
        e.hsync = (c.hcount >= h_count_w'(h_active + h_front)) &&
                  (c.hcount < h_count_w'(h_active + h_front + h_sync));
        e.vsync = (c.vcount >= v_count_w'(v_active + v_front)) &&
                  (c.vcount < v_count_w'(v_active + v_front + v_sync));
        e.active = is_active(c);
        val = channel_of(p, s.ch);
        hit = (val >= s.th.lower) && (val <= s.th.upper);
        on_line = (c.hcount == held.hcount) || (c.vcount == held.vcount);
        if (!e.active) begin
            e.rgb = black;
        end else if (s.mode == disp_mask) begin
            e.rgb = hit ? white : black;
        end else if ((s.mode == disp_crosshair) && on_line) begin
            e.rgb = white;
        end else begin
            e.rgb = p;
        end
        return e;
    endfunction

    task automatic check_px(input video_px_t got, input video_px_t want, input string what);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_coord(input coord_t got, input coord_t want, input string what);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, want);
        end
    endtask

    task automatic apply_scene(input int idx);
        cur_scene = idx;
        channel = scenes[idx].ch;
        thresh = scenes[idx].th;
        mode = scenes[idx].mode;
    endtask

    // wait for the last fetch of the frame when its blanking has run too
    task automatic wait_frame_end();
        @(negedge clk_pixel);
        while (!((fetch_coord.hcount == h_count_w'(h_total - 1)) &&
                 (fetch_coord.vcount == v_count_w'(v_total - 1)))) begin
            @(negedge clk_pixel);
        end
    endtask

    // frame buffer answers one cycle after the fetch
    initial begin
        pixel_in = '0;
        forever begin
            @(posedge clk_pixel);
            #1;
            pixel_in = next_pix;
        end
    end

    // sample at the falling edge where everything is settled
    always @(negedge clk_pixel) begin
        // raster scans row by row from the origin once reset is gone
        if (recent_reset) begin
            raster_tick = 0;
        end else begin
            raster_want.hcount = h_count_w'(raster_tick % h_total);
            raster_want.vcount = v_count_w'((raster_tick / h_total) % v_total);
            check_coord(fetch_coord, raster_want, "fetch_coord");
            raster_tick++;
        end
        for (int i = 3; i > 0; i--) begin
            hist_coord[i] = hist_coord[i-1];
            hist_pix[i] = hist_pix[i-1];
            hist_scene[i] = hist_scene[i-1];
            hist_valid[i] = hist_valid[i-1];
        end
        hist_coord[0] = fetch_coord;
        hist_pix[0] = model_pixel(fetch_coord, scenes[cur_scene]);
        hist_scene[0] = cur_scene;
        hist_valid[0] = !recent_reset;
        next_pix = hist_pix[0];
        // three stage pipeline from fetch to video_out
        if (hist_valid[3]) begin
            check_px(video_out,
                     expect_px(hist_coord[3], hist_pix[3], scenes[hist_scene[3]], ref_com),
                     "video_out");
        end
        if (com_valid) begin
            pulse_total++;
            pulse_com = com;
            if (is_active(fetch_coord)) begin
                fail_count++;
                $display("error at %0t: com_valid pulsed during active video", $time);
            end
        end
    end

    initial begin
        #watchdog_ns;
        $display("error: watchdog expired after %0d ns before all scenes ran", watchdog_ns);
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        scene_t s;
        coord_t want;
        int     base;
        int     seen;
        void'($urandom(32'h7471b701));
        recent_reset = 1'b1;
        channel = ch_red;
        thresh = '0;
        mode = disp_camera;
        ref_com = '0;
        cur_scene = 0;
        next_pix = '0;
        for (int i = 0; i < 4; i++) begin
            hist_valid[i] = 1'b0;
        end
        // x0, x1, y0, y1, channel, lower, upper, mode, bright colour, empty
        scenes[0] = make_scene(2, 5, 1, 3, ch_red, 128, 255, disp_camera, 24'hf02030, 1'b0);
        scenes[1] = make_scene(9, 14, 4, 7, ch_green, 150, 220, disp_mask, 24'h28c83c, 1'b0);
        scenes[2] = make_scene(6, 9, 2, 6, ch_blue, 128, 255, disp_crosshair, 24'h0a14fa, 1'b0);
        // lit but outside the window so nothing is masked
        scenes[3] = make_scene(3, 8, 3, 5, ch_red, 250, 255, disp_crosshair, 24'hc81010, 1'b1);
        scenes[4] = make_scene(15, 15, 7, 7, ch_red, 100, 200, disp_mask, 24'h963050, 1'b0);
        scenes[5] = make_scene(0, 15, 0, 7, ch_green, 128, 255, disp_crosshair, 24'h80ff80, 1'b0);
        apply_scene(0);
        repeat (8) @(posedge clk_pixel);
        #1;
        recent_reset = 1'b0;
        check_coord(com, '0, "com after reset");
        check_bit(com_valid, 1'b0, "com_valid after reset");
        check_px(video_out, '0, "video_out after reset");
        for (int r = 0; r < n_scenes; r++) begin
            s = scenes[r];
            base = pulse_total;
            wait_frame_end();
            @(posedge clk_pixel);
            #1;
            seen = pulse_total - base;
            if (s.empty) begin
                if (seen != 0) begin
                    fail_count++;
                    $display("error: scene %0d has an empty mask but gave %0d com_valid pulses",
                             r, seen);
                end
                check_coord(com, ref_com, "com held over empty frame");
            end else begin
                want.hcount = h_count_w'(floor_mean(int'(s.x0), int'(s.x1)));
                want.vcount = v_count_w'(floor_mean(int'(s.y0), int'(s.y1)));
                if (seen != 1) begin
                    fail_count++;
                    $display("error: scene %0d expected one com_valid pulse, saw %0d", r, seen);
                end
                check_coord(pulse_com, want, "com at com_valid");
                check_coord(com, want, "com");
                ref_com = want;
            end
            $display("scene %0d done at %0t", r, $time);
            if (r + 1 < n_scenes) begin
                apply_scene(r + 1);
            end
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        if ((mismatch_count + fail_count) == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/led_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module led_tracker_top import tracker_pkg::*; #(
    parameter int h_active = 1280,
    parameter int h_front = 110,
    parameter int h_sync = 40,
    parameter int h_back = 220,
    parameter int v_active = 720,
    parameter int v_front = 5,
    parameter int v_sync = 5,
    parameter int v_back = 20
) (
    input  logic      clk_pixel,
    input  logic      recent_reset,
    input  rgb_t      pixel_in,
    input  channel_e  channel,
    input  thresh_t   thresh,
    input  display_e  mode,
    output coord_t    fetch_coord,
    output video_px_t video_out,
    output coord_t    com,
    output logic      com_valid
);

    // stage 0 raster position
    timing_t fetch;

    // stage 1 timing, aligned with pixel_in
    timing_t timing_s1;

    // stage 2 outputs of the threshold stage
    timing_t timing_s2;
    rgb_t    pixel_s2;
    logic    mask_s2;

    video_timing #(
        .h_active(h_active),
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_active(v_active),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back)
    ) u_timing (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .fetch       (fetch)
    );

    // frame buffer answers one cycle after the request
    assign fetch_coord = fetch.coord;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            timing_s1 <= '0;
        end else begin
            timing_s1 <= fetch;
        end
    end

    mask_threshold u_mask (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .timing_in   (timing_s1),
        .pixel_in    (pixel_in),
        .channel     (channel),
        .thresh      (thresh),
        .timing_out  (timing_s2),
        .pixel_out   (pixel_s2),
        .mask        (mask_s2)
    );

    centroid_accum u_centroid (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .timing_in   (timing_s2),
        .mask        (mask_s2),
        .com         (com),
        .com_valid   (com_valid)
    );

    // held com feeds the crosshair of the following frame
    overlay_mux u_overlay (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .timing_in   (timing_s2),
        .pixel_in    (pixel_s2),
        .mask        (mask_s2),
        .com         (com),
        .mode        (mode),
        .video_out   (video_out)
    );

endmodule

`default_nettype wire

/* design/overlay_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module overlay_mux import tracker_pkg::*; (
    input  logic      clk_pixel,
    input  logic      recent_reset,
    input  timing_t   timing_in,
    input  rgb_t      pixel_in,
    input  logic      mask,
    input  coord_t    com,
    input  display_e  mode,
    output video_px_t video_out
);

    localparam rgb_t rgb_white = '{red: '1, green: '1, blue: '1};
    localparam rgb_t rgb_black = '{red: '0, green: '0, blue: '0};

    logic on_cross;
    rgb_t mask_px;
    rgb_t cross_px;
    rgb_t picked;

    // crosshair lines through the held centre
    assign on_cross = (timing_in.coord.hcount == com.hcount) ||
                      (timing_in.coord.vcount == com.vcount);

    // mask picture is pure white or black
    assign mask_px = mask ? rgb_white : rgb_black;

    // white lines over the camera picture
    assign cross_px = on_cross ? rgb_white : pixel_in;

    always_comb begin
        if (!timing_in.active) begin
            // nothing shows in blanking
            picked = rgb_black;
        end else begin
            case (mode)
                disp_camera:    picked = pixel_in;
                disp_mask:      picked = mask_px;
                disp_crosshair: picked = cross_px;
                default:        picked = pixel_in;
            endcase
        end
    end

    // stage 3 output register
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            video_out <= '0;
        end else begin
            video_out.hsync <= timing_in.hsync;
            video_out.vsync <= timing_in.vsync;
            video_out.active <= timing_in.active;
            video_out.rgb <= picked;
        end
    end

endmodule

`default_nettype wire

/* design/centroid_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module centroid_accum import tracker_pkg::*; (
    input  logic    clk_pixel,
    input  logic    recent_reset,
    input  timing_t timing_in,
    input  logic    mask,
    output coord_t  com,
    output logic    com_valid
);

    localparam int cnt_w = $clog2(sum_w);
    localparam int rq_w = pix_count_w + sum_w;
    localparam logic [cnt_w-1:0] last_bit = cnt_w'(sum_w - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_divide,
        st_done
    } div_state_e;

    div_state_e state;

    // running totals for the frame being scanned
    logic [sum_w-1:0]       sum_x;
    logic [sum_w-1:0]       sum_y;
    logic [pix_count_w-1:0] count;

    // latched frame being divided
    // upper part is the remainder, lower part shifts dividend out and quotient in
    logic [rq_w-1:0]        rq_x;
    logic [rq_w-1:0]        rq_y;
    logic [pix_count_w-1:0] divisor;
    logic [cnt_w-1:0]       bit_cnt;

    // one restoring step
    function automatic logic [rq_w-1:0] div_step(
        input logic [rq_w-1:0]        rq,
        input logic [pix_count_w-1:0] d
    );
        logic [pix_count_w:0]   trial;
        logic [pix_count_w-1:0] rem_next;
        logic                   q_bit;
        // remainder with the next dividend bit brought down
        trial = rq[rq_w-1:sum_w-1];
        q_bit = (trial >= {1'b0, d});
        // trial below d already fits the remainder width
        rem_next = q_bit ? pix_count_w'(trial - {1'b0, d}) : trial[pix_count_w-1:0];
        return {rem_next, rq[sum_w-2:0], q_bit};
    endfunction

    // frame accumulation
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (timing_in.new_frame) begin
            // totals move to the divider below
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (mask) begin
            sum_x <= sum_x + sum_w'(timing_in.coord.hcount);
            sum_y <= sum_y + sum_w'(timing_in.coord.vcount);
            count <= count + 1'b1;
        end
    end

    // divider control
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state <= st_idle;
            bit_cnt <= '0;
            com <= '0;
            com_valid <= 1'b0;
        end else begin
            com_valid <= 1'b0;
            case (state)
                st_idle: begin
                    // empty frames leave com alone
                    if (timing_in.new_frame && (count != '0)) begin
                        state <= st_divide;
                        bit_cnt <= '0;
                    end
                end
                st_divide: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == last_bit) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    // means fit the raster so upper quotient bits are zero
                    com.hcount <= rq_x[h_count_w-1:0];
                    com.vcount <= rq_y[v_count_w-1:0];
                    com_valid <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // divider datapath
    always_ff @(posedge clk_pixel) begin
        if ((state == st_idle) && timing_in.new_frame) begin
            rq_x <= {{pix_count_w{1'b0}}, sum_x};
            rq_y <= {{pix_count_w{1'b0}}, sum_y};
            divisor <= count;
        end else if (state == st_divide) begin
            // both axes share the count as divisor
            rq_x <= div_step(rq_x, divisor);
            rq_y <= div_step(rq_y, divisor);
        end
    end

endmodule

`default_nettype wire

/* design/mask_threshold.sv */
`timescale 1ns/1ps
`default_nettype none

module mask_threshold import tracker_pkg::*; (
    input  logic     clk_pixel,
    input  logic     recent_reset,
    input  timing_t  timing_in,
    input  rgb_t     pixel_in,
    input  channel_e channel,
    input  thresh_t  thresh,
    output timing_t  timing_out,
    output rgb_t     pixel_out,
    output logic     mask
);

    logic [color_w-1:0] selected;
    logic               in_range;

    // pick the channel under test
    always_comb begin
        case (channel)
            ch_red:   selected = pixel_in.red;
            ch_green: selected = pixel_in.green;
            ch_blue:  selected = pixel_in.blue;
            default:  selected = pixel_in.red;
        endcase
    end

    // inclusive on both ends
    assign in_range = (selected >= thresh.lower) && (selected <= thresh.upper);

    // mask and timing carry control bits
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            mask <= 1'b0;
            timing_out <= '0;
        end else begin
            // blanking never counts as a hit
            mask <= in_range && timing_in.active;
            timing_out <= timing_in;
        end
    end

    // pixel payload travels beside the mask
    always_ff @(posedge clk_pixel) begin
        pixel_out <= pixel_in;
    end

endmodule

`default_nettype wire

/* design/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing import tracker_pkg::*; #(
    parameter int h_active = 1280,
    parameter int h_front = 110,
    parameter int h_sync = 40,
    parameter int h_back = 220,
    parameter int v_active = 720,
    parameter int v_front = 5,
    parameter int v_sync = 5,
    parameter int v_back = 20
) (
    input  logic    clk_pixel,
    input  logic    recent_reset,
    output timing_t fetch
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // boundaries sized to the counters
    localparam logic [h_count_w-1:0] h_act_end = h_count_w'(h_active);
    localparam logic [h_count_w-1:0] h_sync_start = h_count_w'(h_active + h_front);
    localparam logic [h_count_w-1:0] h_sync_end = h_count_w'(h_active + h_front + h_sync);
    localparam logic [h_count_w-1:0] h_last = h_count_w'(h_total - 1);

    localparam logic [v_count_w-1:0] v_act_end = v_count_w'(v_active);
    localparam logic [v_count_w-1:0] v_sync_start = v_count_w'(v_active + v_front);
    localparam logic [v_count_w-1:0] v_sync_end = v_count_w'(v_active + v_front + v_sync);
    localparam logic [v_count_w-1:0] v_last = v_count_w'(v_total - 1);

    logic [h_count_w-1:0] hcount;
    logic [v_count_w-1:0] vcount;

    // horizontal counter wraps at the line end
    // vertical counter steps once per line
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_last) begin
            hcount <= '0;
            if (vcount == v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // decode straight from the counters
    always_comb begin
        fetch.coord.hcount = hcount;
        fetch.coord.vcount = vcount;
        fetch.active = (hcount < h_act_end) && (vcount < v_act_end);
        // sync pulses sit after the front porch
        fetch.hsync = (hcount >= h_sync_start) && (hcount < h_sync_end);
        fetch.vsync = (vcount >= v_sync_start) && (vcount < v_sync_end);
        // first blanking pixel after the last active line
        fetch.new_frame = (hcount == h_act_end) && (vcount == v_act_end);
    end

endmodule

`default_nettype wire

/* design/tracker_pkg.sv */
`default_nettype none

package tracker_pkg;

    // raster counter widths
    localparam int h_count_w = 11;
    localparam int v_count_w = 10;

    // one colour channel
    localparam int color_w = 8;

    // per-frame accumulators
    localparam int sum_w = 32;
    localparam int pix_count_w = 21;

    typedef struct packed {
        logic [color_w-1:0] red;
        logic [color_w-1:0] green;
        logic [color_w-1:0] blue;
    } rgb_t;

    // raster position, also used for the held centre of mass
    typedef struct packed {
        logic [h_count_w-1:0] hcount;
        logic [v_count_w-1:0] vcount;
    } coord_t;

    typedef struct packed {
        coord_t coord;
        logic   hsync;
        logic   vsync;
        logic   active;
        logic   new_frame;
    } timing_t;

    // pixel as it leaves the design
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        rgb_t rgb;
    } video_px_t;

    // both bounds are inclusive
    typedef struct packed {
        logic [color_w-1:0] lower;
        logic [color_w-1:0] upper;
    } thresh_t;

    typedef enum logic [1:0] {
        ch_red,
        ch_green,
        ch_blue
    } channel_e;

    typedef enum logic [1:0] {
        disp_camera,
        disp_mask,
        disp_crosshair
    } display_e;

endpackage

`default_nettype wire
